// ==== xbar_pkg.sv ====
/* Crossbar sizes and widths, message opcode and size enums,
   and the stream header layout shared by the crossbar blocks */
package xbar_pkg;

  localparam int num_source_lp    = 3;
  localparam int num_sink_lp      = 2;
  localparam int lg_num_source_lp = $clog2(num_source_lp);
  localparam int lg_num_sink_lp   = $clog2(num_sink_lp);

  localparam int data_width_lp    = 32;
  localparam int max_beats_lp     = 8;  // Largest block transfer
  localparam int lg_max_beats_lp  = $clog2(max_beats_lp);
  localparam int addr_width_lp    = 16;

  typedef enum logic [1:0]
  {
    e_msg_rd      = 2'b00
    ,e_msg_wr     = 2'b01
    ,e_msg_uc_rd  = 2'b10
    ,e_msg_uc_wr  = 2'b11
  } msg_opcode_e;

  // Log2 of the number of beats in a write
  typedef enum logic [1:0]
  {
    e_size_1  = 2'b00
    ,e_size_2 = 2'b01
    ,e_size_4 = 2'b10
    ,e_size_8 = 2'b11
  } msg_size_e;

  localparam int header_width_lp = 2 + 2 + lg_num_source_lp + addr_width_lp;

  // Repeated unchanged on every beat of a message
  typedef struct packed
  {
    msg_opcode_e                 opcode;
    msg_size_e                   size;
    logic [lg_num_source_lp-1:0] src_id;
    logic [addr_width_lp-1:0]    addr;
  } msg_header_s;

endpackage

// ==== stream_two_fifo.sv ====
/* Two-entry FIFO holding destination, header and data of one source,
   valid/ready-and on the input side and valid/yumi on the output side */
`timescale 1ns/1ps

module stream_two_fifo
  (input                                         clk_i
   , input                                       reset_i

   , input [xbar_pkg::lg_num_sink_lp-1:0]        dst_i
   , input xbar_pkg::msg_header_s                header_i
   , input [xbar_pkg::data_width_lp-1:0]         data_i
   , input                                       v_i
   , output logic                                ready_o

   , output logic [xbar_pkg::lg_num_sink_lp-1:0] dst_o
   , output xbar_pkg::msg_header_s               header_o
   , output logic [xbar_pkg::data_width_lp-1:0]  data_o
   , output logic                                v_o
   , input                                       yumi_i
   );

  import xbar_pkg::*;

  logic [lg_num_sink_lp-1:0] dst_mem_r    [2];
  msg_header_s               header_mem_r [2];
  logic [data_width_lp-1:0]  data_mem_r   [2];

  logic rd_ptr_r, wr_ptr_r;
  logic full_r, empty_r;
  logic enq;

  assign enq     = v_i & ~full_r;
  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;

  assign dst_o    = dst_mem_r[rd_ptr_r];
  assign header_o = header_mem_r[rd_ptr_r];
  assign data_o   = data_mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
    begin
      if (enq)
        begin
          dst_mem_r[wr_ptr_r]    <= dst_i;
          header_mem_r[wr_ptr_r] <= header_i;
          data_mem_r[wr_ptr_r]   <= data_i;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          rd_ptr_r <= 1'b0;
          wr_ptr_r <= 1'b0;
          full_r   <= 1'b0;
          empty_r  <= 1'b1;
        end
      else
        begin
          if (enq)
            wr_ptr_r <= ~wr_ptr_r;
          if (yumi_i)
            rd_ptr_r <= ~rd_ptr_r;

          // Occupancy only changes when one side moves alone
          if (enq & ~yumi_i)
            begin
              empty_r <= 1'b0;
              full_r  <= (~wr_ptr_r == rd_ptr_r);
            end
          else if (yumi_i & ~enq)
            begin
              full_r  <= 1'b0;
              empty_r <= (~rd_ptr_r == wr_ptr_r);
            end
        end
    end

endmodule

// ==== stream_beat_counter.sv ====
/* Per-sink beat counter that flags the last beat of a message */
`timescale 1ns/1ps

module stream_beat_counter
  (input                           clk_i
   , input                         reset_i

   , input xbar_pkg::msg_header_s  header_i
   , input                         en_i
   , output logic                  last_o
   );

  import xbar_pkg::*;

  logic [lg_max_beats_lp-1:0] count_r;
  logic [lg_max_beats_lp-1:0] size_last;
  logic [lg_max_beats_lp-1:0] last_cnt;

  // Index of the final beat for a write of the given size
  always_comb
    begin
      case (header_i.size)
        e_size_2: size_last = lg_max_beats_lp'(1);
        e_size_4: size_last = lg_max_beats_lp'(3);
        e_size_8: size_last = lg_max_beats_lp'(max_beats_lp-1);
        default:  size_last = '0;
      endcase
    end

  always_comb
    begin
      case (header_i.opcode)
        e_msg_wr, e_msg_uc_wr: last_cnt = size_last;
        default:               last_cnt = '0;  // Reads carry one beat
      endcase
    end

  assign last_o = (count_r == last_cnt);

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        count_r <= '0;
      else if (en_i)
        begin
          if (last_o)
            count_r <= '0;  // Next beat starts a new message
          else
            count_r <= count_r + 1'b1;
        end
    end

endmodule

// ==== stream_xbar_control.sv ====
/* Crossbar control with per-sink round-robin arbitration and message locking,
   producing source yumi, sink valid and one-hot grants */
`timescale 1ns/1ps

module stream_xbar_control
  (input                                                                  clk_i
   , input                                                                reset_i

   , input [xbar_pkg::num_source_lp-1:0]                                  valid_i
   , input [xbar_pkg::num_source_lp-1:0][xbar_pkg::lg_num_sink_lp-1:0]    dst_i
   , output logic [xbar_pkg::num_source_lp-1:0]                           yumi_o

   , input [xbar_pkg::num_sink_lp-1:0]                                    ready_and_i
   , output logic [xbar_pkg::num_sink_lp-1:0]                             valid_o
   , input [xbar_pkg::num_sink_lp-1:0]                                    unlock_i
   , output logic [xbar_pkg::num_sink_lp-1:0][xbar_pkg::num_source_lp-1:0] grant_one_hot_o
   );

  import xbar_pkg::*;

  for (genvar j = 0; j < num_sink_lp; j++)
    begin : sink
      logic [num_source_lp-1:0]    req;
      logic                        rr_v;
      logic [lg_num_source_lp-1:0] rr_src;
      logic [lg_num_source_lp-1:0] grant_src;
      logic [lg_num_source_lp-1:0] ptr_next;
      logic [lg_num_source_lp-1:0] ptr_r;
      logic [lg_num_source_lp-1:0] locked_src_r;
      logic                        lock_r;

      // Sources whose head beat is headed for this sink
      for (genvar i = 0; i < num_source_lp; i++)
        begin : src
          assign req[i] = valid_i[i] & (dst_i[i] == lg_num_sink_lp'(j));
        end

      // First requester at or after the pointer wins
      always_comb
        begin
          logic [lg_num_source_lp:0] idx;
          rr_v   = 1'b0;
          rr_src = ptr_r;
          for (int k = 0; k < num_source_lp; k++)
            begin
              idx = {1'b0, ptr_r} + (lg_num_source_lp+1)'(k);
              if (idx >= (lg_num_source_lp+1)'(num_source_lp))
                idx = idx - (lg_num_source_lp+1)'(num_source_lp);
              if (~rr_v & req[idx[lg_num_source_lp-1:0]])
                begin
                  rr_v   = 1'b1;
                  rr_src = idx[lg_num_source_lp-1:0];
                end
            end
        end

      assign grant_src = lock_r ? locked_src_r : rr_src;
      assign valid_o[j] = lock_r ? req[locked_src_r] : rr_v;
      assign grant_one_hot_o[j] = (lock_r | rr_v)
                                  ? (num_source_lp'(1) << grant_src)
                                  : '0;

      assign ptr_next = (grant_src == lg_num_source_lp'(num_source_lp-1))
                        ? '0
                        : grant_src + 1'b1;

      always_ff @(posedge clk_i)
        begin
          if (reset_i)
            begin
              lock_r       <= 1'b0;
              locked_src_r <= '0;
              ptr_r        <= '0;
            end
          else if (unlock_i[j])
            begin
              lock_r <= 1'b0;
              ptr_r  <= ptr_next;  // Move past the source that just finished
            end
          else if (~lock_r & rr_v)
            begin
              lock_r       <= 1'b1;
              locked_src_r <= rr_src;
            end
        end
    end

  // A source is popped by the handshake of the sink holding its grant
  always_comb
    begin
      yumi_o = '0;
      for (int j = 0; j < num_sink_lp; j++)
        yumi_o |= grant_one_hot_o[j] & {num_source_lp{valid_o[j] & ready_and_i[j]}};
    end

endmodule

// ==== stream_xbar.sv ====
/* Stream message crossbar top with source FIFOs, arbitration control,
   per-sink beat counters and the one-hot output multiplexer */
`timescale 1ns/1ps

module stream_xbar
  (input                                                                   clk_i
   , input                                                                 reset_i

   , input xbar_pkg::msg_header_s [xbar_pkg::num_source_lp-1:0]            msg_header_i
   , input [xbar_pkg::num_source_lp-1:0][xbar_pkg::data_width_lp-1:0]      msg_data_i
   , input [xbar_pkg::num_source_lp-1:0][xbar_pkg::lg_num_sink_lp-1:0]     msg_dst_i
   , input [xbar_pkg::num_source_lp-1:0]                                   msg_v_i
   , output logic [xbar_pkg::num_source_lp-1:0]                            msg_ready_and_o

   , output xbar_pkg::msg_header_s [xbar_pkg::num_sink_lp-1:0]             msg_header_o
   , output logic [xbar_pkg::num_sink_lp-1:0][xbar_pkg::data_width_lp-1:0] msg_data_o
   , output logic [xbar_pkg::num_sink_lp-1:0]                              msg_v_o
   , input [xbar_pkg::num_sink_lp-1:0]                                     msg_ready_and_i
   );

  import xbar_pkg::*;

  localparam int combine_width_lp = header_width_lp + data_width_lp;

  logic [num_source_lp-1:0]                     fifo_v;
  logic [num_source_lp-1:0]                     fifo_yumi;
  logic [num_source_lp-1:0][lg_num_sink_lp-1:0] fifo_dst;
  msg_header_s [num_source_lp-1:0]              fifo_header;
  logic [num_source_lp-1:0][data_width_lp-1:0]  fifo_data;

  logic [num_sink_lp-1:0][num_source_lp-1:0]    grant_one_hot;
  logic [num_sink_lp-1:0]                       unlock;

  logic [num_source_lp-1:0][combine_width_lp-1:0] source_combine;
  logic [num_sink_lp-1:0][combine_width_lp-1:0]   sink_combine;

  for (genvar i = 0; i < num_source_lp; i++)
    begin : buffer
      stream_two_fifo in_fifo
        (.clk_i(clk_i)
         ,.reset_i(reset_i)

         ,.dst_i(msg_dst_i[i])
         ,.header_i(msg_header_i[i])
         ,.data_i(msg_data_i[i])
         ,.v_i(msg_v_i[i])
         ,.ready_o(msg_ready_and_o[i])

         ,.dst_o(fifo_dst[i])
         ,.header_o(fifo_header[i])
         ,.data_o(fifo_data[i])
         ,.v_o(fifo_v[i])
         ,.yumi_i(fifo_yumi[i])
         );

      assign source_combine[i] = {fifo_header[i], fifo_data[i]};
    end

  stream_xbar_control cbc
    (.clk_i(clk_i)
     ,.reset_i(reset_i)

     ,.valid_i(fifo_v)
     ,.dst_i(fifo_dst)
     ,.yumi_o(fifo_yumi)

     ,.ready_and_i(msg_ready_and_i)
     ,.valid_o(msg_v_o)
     ,.unlock_i(unlock)
     ,.grant_one_hot_o(grant_one_hot)
     );

  // Grants are one-hot so an OR of the selected sources is enough
  always_comb
    begin
      for (int j = 0; j < num_sink_lp; j++)
        begin
          sink_combine[j] = '0;
          for (int i = 0; i < num_source_lp; i++)
            if (grant_one_hot[j][i])
              sink_combine[j] |= source_combine[i];
        end
    end

  for (genvar j = 0; j < num_sink_lp; j++)
    begin : sink
      logic last;

      assign {msg_header_o[j], msg_data_o[j]} = sink_combine[j];

      stream_beat_counter beat_counter
        (.clk_i(clk_i)
         ,.reset_i(reset_i)

         ,.header_i(msg_header_o[j])
         ,.en_i(msg_v_o[j] & msg_ready_and_i[j])
         ,.last_o(last)
         );

      assign unlock[j] = msg_v_o[j] & msg_ready_and_i[j] & last;  // Final beat handed off
    end

endmodule

// ==== tb_stream_xbar_checks.svh ====
/* Expected-beat queues per source and sink pair, and the typed compare
   tasks of the crossbar testbench */

  localparam int num_pairs_lp = num_source_lp * num_sink_lp;
  localparam int exp_depth_lp = 1024;

  msg_header_s              exp_hdr  [num_pairs_lp][exp_depth_lp];
  logic [data_width_lp-1:0] exp_data [num_pairs_lp][exp_depth_lp];
  int                       exp_head [num_pairs_lp];  // Next beat the sink should show
  int                       exp_tail [num_pairs_lp];

  task automatic push_expected(input int pair, input msg_header_s hdr,
                               input logic [data_width_lp-1:0] data);
    if (exp_tail[pair] >= exp_depth_lp)
      stop_on_error("expected beat storage is full, the vector file is too long");
    exp_hdr[pair][exp_tail[pair]]  = hdr;
    exp_data[pair][exp_tail[pair]] = data;
    exp_tail[pair]++;
  endtask

  function automatic int expected_left(input int pair);
    return exp_tail[pair] - exp_head[pair];
  endfunction

  task automatic check_header(input string name, input msg_header_s got,
                              input msg_header_s exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_data(input string name, input logic [data_width_lp-1:0] got,
                            input logic [data_width_lp-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

// ==== tb_stream_xbar.sv ====
/* Testbench for the stream crossbar with vector replay, random sink
   back-pressure and a per source and sink scoreboard */
`timescale 1ns/1ps

module tb_stream_xbar;

  import xbar_pkg::*;

  localparam int max_msgs_lp    = 128;
  localparam int wait_limit_lp  = 1000;  // Cycles one source beat may wait
  localparam int drain_limit_lp = 20000;

  logic                                          clk_i;
  logic                                          reset_i;
  msg_header_s [num_source_lp-1:0]               msg_header_i;
  logic [num_source_lp-1:0][data_width_lp-1:0]   msg_data_i;
  logic [num_source_lp-1:0][lg_num_sink_lp-1:0]  msg_dst_i;
  logic [num_source_lp-1:0]                      msg_v_i;
  logic [num_source_lp-1:0]                      msg_ready_and_o;
  msg_header_s [num_sink_lp-1:0]                 msg_header_o;
  logic [num_sink_lp-1:0][data_width_lp-1:0]     msg_data_o;
  logic [num_sink_lp-1:0]                        msg_v_o;
  logic [num_sink_lp-1:0]                        msg_ready_and_i;

  msg_header_s               msg_hdr  [max_msgs_lp];
  logic [lg_num_sink_lp-1:0] msg_dst  [max_msgs_lp];
  logic [data_width_lp-1:0]  msg_base [max_msgs_lp];
  int                        src_msgs [num_source_lp][max_msgs_lp];
  int                        src_msg_cnt [num_source_lp];
  int                        done_msgs [num_source_lp];
  int                        beats_left [num_sink_lp];  // Zero between messages
  int                        cur_src [num_sink_lp];
  logic                      stall_seen [num_sink_lp];
  msg_header_s               stall_hdr [num_sink_lp];
  logic [data_width_lp-1:0]  stall_data [num_sink_lp];
  int                        num_msgs;
  int                        sent_beats;
  int                        received_beats;
  logic                      running;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  `include "tb_stream_xbar_checks.svh"

  // Writes stream 2**size beats and reads carry a single beat
  function automatic int beats_of(input msg_header_s hdr);
    if (hdr.opcode == e_msg_wr || hdr.opcode == e_msg_uc_wr)
      return 1 << hdr.size;
    return 1;
  endfunction

  stream_xbar u_dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.msg_header_i(msg_header_i)
     ,.msg_data_i(msg_data_i)
     ,.msg_dst_i(msg_dst_i)
     ,.msg_v_i(msg_v_i)
     ,.msg_ready_and_o(msg_ready_and_o)
     ,.msg_header_o(msg_header_o)
     ,.msg_data_o(msg_data_o)
     ,.msg_v_o(msg_v_o)
     ,.msg_ready_and_i(msg_ready_and_i)
     );

  always #20 clk_i = ~clk_i;

  task automatic load_vectors();
    int fd, cnt, s, d, op, sz, addr, base;
    string line;
    msg_header_s hdr;
    fd = $fopen("stream_xbar_vectors.txt", "r");
    if (fd == 0)
      stop_on_error("could not open stream_xbar_vectors.txt");
    while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line.getc(0) == "#")
          continue;
        cnt = $sscanf(line, "%h %h %h %h %h %h", s, d, op, sz, addr, base);
        if (cnt <= 0)
          continue;
        if (cnt != 6 || s >= num_source_lp || d >= num_sink_lp || num_msgs >= max_msgs_lp)
          stop_on_error($sformatf("vector file line is not usable: %s", line));
        hdr.opcode = msg_opcode_e'(op[1:0]);
        hdr.size   = msg_size_e'(sz[1:0]);
        hdr.src_id = s[lg_num_source_lp-1:0];
        hdr.addr   = addr[addr_width_lp-1:0];
        for (int k = 0; k < beats_of(hdr); k++)
          push_expected(s * num_sink_lp + d, hdr, base + k);
        sent_beats += beats_of(hdr);
        msg_hdr[num_msgs]  = hdr;
        msg_dst[num_msgs]  = d[lg_num_sink_lp-1:0];
        msg_base[num_msgs] = base;
        src_msgs[s][src_msg_cnt[s]] = num_msgs;
        src_msg_cnt[s]++;
        num_msgs++;
      end
    $fclose(fd);
  endtask

  task automatic drive_source(input int s);
    int m, waited;
    logic taken;
    for (int n = 0; n < src_msg_cnt[s]; n++)
      begin
        m = src_msgs[s][n];
        for (int k = 0; k < beats_of(msg_hdr[m]); k++)
          begin
            msg_v_i[s]      = 1'b1;
            msg_dst_i[s]    = msg_dst[m];
            msg_header_i[s] = msg_hdr[m];
            msg_data_i[s]   = msg_base[m] + k;
            taken  = 1'b0;
            waited = 0;
            while (!taken)
              begin
                @(negedge clk_i);
                taken = msg_ready_and_o[s];  // The beat moves on the next rising edge
                @(posedge clk_i);
                #1;
                waited++;
                if (!taken && waited >= wait_limit_lp)
                  stop_on_error($sformatf("source %0d beat was not accepted in %0d cycles",
                                          s, waited));
              end
          end
      end
    msg_v_i[s] = 1'b0;
  endtask

  task automatic take_beat(input int j);
    msg_header_s hdr;
    int src, pair;
    hdr = msg_header_o[j];
    src = hdr.src_id;
    if (src >= num_source_lp)
      stop_on_error($sformatf("sink %0d delivered a beat with unknown source id %0d", j, src));
    pair = src * num_sink_lp + j;
    if (expected_left(pair) == 0)
      stop_on_error($sformatf("sink %0d delivered a beat that source %0d never sent there",
                              j, src));
    check_header("msg_header_o", hdr, exp_hdr[pair][exp_head[pair]]);
    check_data("msg_data_o", msg_data_o[j], exp_data[pair][exp_head[pair]]);
    exp_head[pair]++;
    if (beats_left[j] == 0)
      begin
        cur_src[j]    = src;
        beats_left[j] = beats_of(hdr);
      end
    else
      check_count("msg_header_o.src_id", src, cur_src[j]);  // No interleaving within a message
    beats_left[j]--;
    if (beats_left[j] == 0)
      done_msgs[src]++;
    received_beats++;
  endtask

  task automatic watch_sink(input int j);
    // A stalled beat must still be offered unchanged
    if (stall_seen[j])
      begin
        check_flag("msg_v_o", msg_v_o[j], 1'b1);
        check_header("msg_header_o", msg_header_o[j], stall_hdr[j]);
        check_data("msg_data_o", msg_data_o[j], stall_data[j]);
      end
    stall_seen[j] = msg_v_o[j] & ~msg_ready_and_i[j];
    stall_hdr[j]  = msg_header_o[j];
    stall_data[j] = msg_data_o[j];
    if (msg_v_o[j] & msg_ready_and_i[j])
      take_beat(j);
  endtask

  initial
    begin
      void'($urandom(32'hdfde_4f00));
      forever
        begin
          @(posedge clk_i);
          if (running)
            begin
              #1;
              for (int j = 0; j < num_sink_lp; j++)
                msg_ready_and_i[j] = ($urandom % 4) != 0;
            end
        end
    end

  always @(negedge clk_i)
    begin
      if (running)
        for (int j = 0; j < num_sink_lp; j++)
          watch_sink(j);
    end

  initial
    begin
      int waited;
      clk_i           = 1'b0;
      reset_i         = 1'b1;
      msg_v_i         = '0;
      msg_dst_i       = '0;
      msg_header_i    = '0;
      msg_data_i      = '0;
      msg_ready_and_i = '0;
      running         = 1'b0;
      num_msgs        = 0;
      sent_beats      = 0;
      received_beats  = 0;
      for (int s = 0; s < num_source_lp; s++)
        begin
          src_msg_cnt[s] = 0;
          done_msgs[s]   = 0;
        end
      for (int j = 0; j < num_sink_lp; j++)
        begin
          beats_left[j] = 0;
          cur_src[j]    = 0;
          stall_seen[j] = 1'b0;
        end
      for (int p = 0; p < num_pairs_lp; p++)
        begin
          exp_head[p] = 0;
          exp_tail[p] = 0;
        end
      load_vectors();

      // Reset is sampled on four rising edges
      repeat (3)
        begin
          @(posedge clk_i);
          @(negedge clk_i);
          for (int j = 0; j < num_sink_lp; j++)
            check_flag($sformatf("msg_v_o[%0d]", j), msg_v_o[j], 1'b0);
        end
      @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      @(negedge clk_i);
      for (int s = 0; s < num_source_lp; s++)
        check_flag($sformatf("msg_ready_and_o[%0d]", s), msg_ready_and_o[s], 1'b1);
      @(posedge clk_i);
      #1;
      running = 1'b1;
      fork
        drive_source(0);
        drive_source(1);
        drive_source(2);
      join

      // With every source done the crossbar goes quiet once all buffered beats are out
      waited = 0;
      @(negedge clk_i);
      while (msg_v_o != '0 && waited < drain_limit_lp)
        begin
          @(negedge clk_i);
          waited++;
        end
      if (msg_v_o != '0)
        stop_on_error($sformatf("simulation timed out with %0d of %0d beats delivered",
                                received_beats, sent_beats));
      else
        begin
          check_count("received_beats", received_beats, sent_beats);
          for (int p = 0; p < num_pairs_lp; p++)
            check_count("expected beats left", expected_left(p), 0);
          for (int s = 0; s < num_source_lp; s++)
            begin
              if (done_msgs[s] == 0)
                stop_on_error($sformatf("source %0d got no message through", s));
              check_count("messages completed", done_msgs[s], src_msg_cnt[s]);
            end
          $display("SIMULATION PASSED");
          $finish;
        end
    end

endmodule

// ==== build.f ====
+incdir+.
xbar_pkg.sv
stream_two_fifo.sv
stream_beat_counter.sv
stream_xbar_control.sv
stream_xbar.sv
tb_stream_xbar.sv

// ==== stream_xbar_vectors.txt ====
# src dst opcode size addr data_base, all hex; opcode 0 rd 1 wr 2 uc_rd 3 uc_wr
# size is log2 of the beat count of a write; beat k of a message carries data_base+k
0 0 1 2 1000 00001000
1 1 0 0 2000 00002000
2 0 3 1 3000 00003000
0 1 2 0 1010 00001100
1 0 1 3 2010 00002100
2 1 1 0 3010 00003100
0 0 0 0 1020 00001200
1 1 3 2 2020 00002200
2 0 2 0 3020 00003200
0 1 1 1 1030 00001300
1 0 0 0 2030 00002300
2 1 3 3 3030 00003300
0 0 1 3 1100 10000000
1 0 1 3 2100 20000000
2 0 1 3 3100 30000000
0 0 3 2 1110 10000100
1 0 3 2 2110 20000100
2 0 3 2 3110 30000100
0 0 0 0 1120 10000200
1 0 2 0 2120 20000200
2 0 0 0 3120 30000200
0 1 1 2 1200 40000000
1 1 1 2 2200 50000000
2 1 1 2 3200 60000000
0 1 0 3 1210 40000100
1 1 2 2 2210 50000100
2 1 3 1 3210 60000100
0 0 3 0 1300 70000000
0 1 1 3 1310 70000100
1 0 0 1 2300 80000000
1 1 1 1 2310 80000100
2 0 1 2 3300 90000000
2 1 2 3 3310 90000100
0 0 1 1 14a0 a0000000
1 0 3 3 24b0 b0000000
2 0 0 2 34c0 c0000000
0 1 3 1 14d0 d0000000
1 1 0 0 24e0 e0000000
2 1 1 3 34f0 f0000000
0 0 2 1 1500 0000a500
